// ==== filelist.f ====
hdl/pc_prof_pkg.sv
hdl/pc_event_encoder.sv
hdl/pc_hist_counters.sv
hdl/pc_prof_csr.sv
hdl/pc_profiler_top.sv
tb/pc_profiler_tb.sv

// ==== hdl/pc_event_encoder.sv ====
module pc_event_encoder #(
  parameter int num_bins_p = 64
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  pc_prof_pkg::core_status_s status_i,
  input  logic                      enable_i,
  input  logic [31:0]               pc_base_i,
  input  logic [4:0]                bin_shift_i,
  output pc_prof_pkg::hist_event_s  event_o
);

  localparam logic [31:0] num_bins_lp = num_bins_p;
  localparam logic [31:0] bin_mask_lp = num_bins_p - 1;

  pc_prof_pkg::core_status_s status_r;
  logic                      enable_r;

  pc_prof_pkg::pc_class_e    cls_n;
  logic [31:0]               pc_sel;
  logic [31:0]               offset;
  logic [31:0]               shifted;
  logic [pc_prof_pkg::max_bin_bits_c-1:0] bin_n;

  logic                      valid_r;
  logic                      in_range_r;
  pc_prof_pkg::pc_class_e    cls_r;
  logic [pc_prof_pkg::max_bin_bits_c-1:0] bin_r;

  always_ff @(posedge clk_i) begin
    status_r <= status_i;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_r <= 1'b0;
      valid_r  <= 1'b0;
    end else begin
      enable_r <= enable_i;
      valid_r  <= enable_r;               // valid follows the enable seen with the status.
    end
  end

  // the first match in priority order wins.
  always_comb begin
    cls_n  = pc_prof_pkg::cls_unknown;
    pc_sel = status_r.exe_pc;
    if (status_r.instr_valid && !status_r.stall_all) begin
      cls_n = pc_prof_pkg::cls_instr;
    end else if (status_r.fp_issue && !status_r.stall_all) begin
      cls_n  = pc_prof_pkg::cls_fp_instr;
      pc_sel = status_r.fp_pc;            // fp ops are charged to their own pc.
    end else if (status_r.flush) begin
      cls_n = pc_prof_pkg::cls_flush;
    end else if (status_r.icache_miss) begin
      cls_n = pc_prof_pkg::cls_icache_miss;
    end else if (status_r.stall_depend) begin
      cls_n = pc_prof_pkg::cls_stall_depend;
    end else if (status_r.stall_remote) begin
      cls_n = pc_prof_pkg::cls_stall_remote;
    end else if (status_r.stall_barrier) begin
      cls_n = pc_prof_pkg::cls_stall_barrier;
    end
  end

  assign offset  = pc_sel - pc_base_i;    // wraps for pcs below the base.
  assign shifted = offset >> bin_shift_i;
  assign bin_n   = shifted[pc_prof_pkg::max_bin_bits_c-1:0]
                 & bin_mask_lp[pc_prof_pkg::max_bin_bits_c-1:0];

  always_ff @(posedge clk_i) begin
    in_range_r <= (shifted < num_bins_lp);
    cls_r      <= cls_n;
    bin_r      <= bin_n;
  end

  assign event_o = '{valid: valid_r, in_range: in_range_r, cls: cls_r, bin: bin_r};

endmodule

// ==== hdl/pc_hist_counters.sv ====
module pc_hist_counters #(
  parameter int num_bins_p      = 64,
  parameter int counter_width_p = 32
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  pc_prof_pkg::hist_event_s   event_i,
  input  logic                       clear_i,
  output logic                       clear_busy_o,
  output logic [31:0]                oor_count_o,
  input  logic                       rd_en_i,
  input  pc_prof_pkg::pc_prof_addr_u rd_addr_i,
  output logic [31:0]                rd_data_o
);

  localparam int bin_bits_lp = $clog2(num_bins_p);
  localparam int idx_bits_lp = bin_bits_lp + pc_prof_pkg::class_width_c;
  localparam int entries_lp  = num_bins_p * pc_prof_pkg::num_classes_c;
  localparam logic [idx_bits_lp-1:0] last_idx_lp = idx_bits_lp'(entries_lp - 1);

  logic [counter_width_p-1:0] mem_r [entries_lp];

  logic [idx_bits_lp-1:0]     ev_idx;
  logic [idx_bits_lp-1:0]     rd_idx;
  logic                       accept;

  logic                       s1_valid_r;
  logic [idx_bits_lp-1:0]     s1_idx_r;
  logic [counter_width_p-1:0] s1_data_r;

  logic                       wb_valid_r;
  logic [idx_bits_lp-1:0]     wb_idx_r;
  logic [counter_width_p-1:0] wb_data_r;

  logic [counter_width_p-1:0] base;
  logic [counter_width_p-1:0] inc;

  logic                       wr_en;
  logic [idx_bits_lp-1:0]     wr_idx;
  logic [counter_width_p-1:0] wr_data;

  logic                       clear_busy_r;
  logic [idx_bits_lp-1:0]     clr_idx_r;
  logic [31:0]                oor_r;

  // entry index is bin in the upper bits and class in the lower bits.
  assign ev_idx = {event_i.bin[bin_bits_lp-1:0], event_i.cls};
  assign rd_idx = {rd_addr_i.counter.bin[bin_bits_lp-1:0], rd_addr_i.counter.cls};

  assign accept = event_i.valid && !clear_i && !clear_busy_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_valid_r <= 1'b0;
    end else begin
      s1_valid_r <= accept && event_i.in_range;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_idx_r  <= ev_idx;
    s1_data_r <= mem_r[ev_idx];
  end

  // the read above misses a write landing on the same edge.
  assign base = (wb_valid_r && (wb_idx_r == s1_idx_r)) ? wb_data_r : s1_data_r;
  assign inc  = (&base) ? base : base + 1'b1;   // saturate at all ones.

  always_comb begin
    if (clear_busy_r) begin
      wr_en   = 1'b1;
      wr_idx  = clr_idx_r;
      wr_data = '0;
    end else begin
      wr_en   = s1_valid_r;
      wr_idx  = s1_idx_r;
      wr_data = inc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_r[wr_idx] <= wr_data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_valid_r <= 1'b0;
    end else begin
      wb_valid_r <= wr_en;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_idx_r  <= wr_idx;
    wb_data_r <= wr_data;
  end

  // sweep zeroes one entry per cycle.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      clear_busy_r <= 1'b0;
      clr_idx_r    <= '0;
    end else if (clear_i) begin
      clear_busy_r <= 1'b1;
      clr_idx_r    <= '0;
    end else if (clear_busy_r) begin
      clr_idx_r <= clr_idx_r + 1'b1;
      if (clr_idx_r == last_idx_lp) begin
        clear_busy_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      oor_r <= '0;
    end else if (accept && !event_i.in_range && !(&oor_r)) begin
      oor_r <= oor_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= 32'(mem_r[rd_idx]);    // zero extended to the bus width.
    end
  end

  assign clear_busy_o = clear_busy_r;
  assign oor_count_o  = oor_r;

endmodule

// ==== hdl/pc_prof_csr.sv ====
module pc_prof_csr (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic [13:0]                awaddr_i,
  input  logic                       awvalid_i,
  output logic                       awready_o,
  input  logic [31:0]                wdata_i,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  output logic                       bvalid_o,
  output logic [1:0]                 bresp_o,
  input  logic                       bready_i,
  input  logic [13:0]                araddr_i,
  input  logic                       arvalid_i,
  output logic                       arready_o,
  output logic                       rvalid_o,
  output logic [31:0]                rdata_o,
  output logic [1:0]                 rresp_o,
  input  logic                       rready_i,
  output pc_prof_pkg::prof_cfg_s     cfg_o,
  input  logic                       clear_busy_i,
  input  logic [31:0]                oor_count_i,
  output logic                       rd_en_o,
  output pc_prof_pkg::pc_prof_addr_u rd_addr_o,
  input  logic [31:0]                rd_data_i
);

  pc_prof_pkg::pc_prof_addr_u aw_addr_r;
  pc_prof_pkg::pc_prof_addr_u ar_addr_r;
  logic [31:0] wdata_r;
  logic        aw_full_r;
  logic        w_full_r;
  logic        bvalid_r;

  logic        ar_pending_r;
  logic        cnt_wait_r;
  logic        rvalid_r;
  logic [31:0] rdata_r;
  logic [31:0] reg_rdata;
  logic        wr_reg_hit;

  logic        enable_r;
  logic [31:0] pc_base_r;
  logic [4:0]  bin_shift_r;
  logic        clear_req_r;

  assign awready_o = !aw_full_r && !bvalid_r;
  assign wready_o  = !w_full_r && !bvalid_r;
  assign arready_o = !ar_pending_r && !cnt_wait_r && !rvalid_r;

  assign wr_reg_hit = !aw_addr_r.csr.region && (aw_addr_r.csr.pad == '0);

  always_ff @(posedge clk_i) begin
    if (awvalid_i && awready_o) begin
      aw_addr_r <= awaddr_i[13:2];
    end
    if (wvalid_i && wready_o) begin
      wdata_r <= wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      aw_full_r   <= 1'b0;
      w_full_r    <= 1'b0;
      bvalid_r    <= 1'b0;
      enable_r    <= 1'b0;
      pc_base_r   <= '0;
      bin_shift_r <= '0;
      clear_req_r <= 1'b0;
    end else begin
      clear_req_r <= 1'b0;
      if (awvalid_i && awready_o) begin
        aw_full_r <= 1'b1;
      end
      if (wvalid_i && wready_o) begin
        w_full_r <= 1'b1;
      end
      if (aw_full_r && w_full_r) begin
        aw_full_r <= 1'b0;
        w_full_r  <= 1'b0;
        bvalid_r  <= 1'b1;
        if (wr_reg_hit) begin
          case (aw_addr_r.csr.reg_idx)
            pc_prof_pkg::reg_ctrl_c: begin
              enable_r    <= wdata_r[0];
              clear_req_r <= wdata_r[1];
            end
            pc_prof_pkg::reg_pc_base_c:   pc_base_r   <= wdata_r;
            pc_prof_pkg::reg_bin_shift_c: bin_shift_r <= wdata_r[4:0];
            default: ;                    // read only or unmapped.
          endcase
        end
      end
      if (bvalid_r && bready_i) begin
        bvalid_r <= 1'b0;
      end
    end
  end

  always_comb begin
    reg_rdata = '0;
    if (ar_addr_r.csr.pad == '0) begin
      case (ar_addr_r.csr.reg_idx)
        pc_prof_pkg::reg_ctrl_c:      reg_rdata = {31'b0, enable_r};
        pc_prof_pkg::reg_status_c:    reg_rdata = {31'b0, clear_busy_i};
        pc_prof_pkg::reg_pc_base_c:   reg_rdata = pc_base_r;
        pc_prof_pkg::reg_bin_shift_c: reg_rdata = {27'b0, bin_shift_r};
        pc_prof_pkg::reg_oor_count_c: reg_rdata = oor_count_i;
        default:                      reg_rdata = '0;
      endcase
    end
  end

  // counter reads spend one extra cycle in cnt_wait for the ram.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ar_pending_r <= 1'b0;
      cnt_wait_r   <= 1'b0;
      rvalid_r     <= 1'b0;
    end else begin
      if (arvalid_i && arready_o) begin
        ar_pending_r <= 1'b1;
      end
      if (ar_pending_r) begin
        ar_pending_r <= 1'b0;
        if (ar_addr_r.csr.region) begin
          cnt_wait_r <= 1'b1;
        end else begin
          rvalid_r <= 1'b1;
        end
      end
      if (cnt_wait_r) begin
        cnt_wait_r <= 1'b0;
        rvalid_r   <= 1'b1;
      end
      if (rvalid_r && rready_i) begin
        rvalid_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (arvalid_i && arready_o) begin
      ar_addr_r <= araddr_i[13:2];
    end
    if (ar_pending_r && !ar_addr_r.csr.region) begin
      rdata_r <= reg_rdata;
    end else if (cnt_wait_r) begin
      rdata_r <= rd_data_i;
    end
  end

  assign rd_en_o   = ar_pending_r && ar_addr_r.counter.region;
  assign rd_addr_o = ar_addr_r;

  assign bvalid_o = bvalid_r;
  assign bresp_o  = 2'b00;
  assign rvalid_o = rvalid_r;
  assign rdata_o  = rdata_r;
  assign rresp_o  = 2'b00;

  assign cfg_o = '{enable: enable_r, pc_base: pc_base_r, bin_shift: bin_shift_r,
                   clear_req: clear_req_r};

endmodule

// ==== hdl/pc_prof_pkg.sv ====
package pc_prof_pkg;

  localparam int class_width_c = 3;
  localparam int num_classes_c = 8;
  localparam int max_bin_bits_c = 8;

  // cycle classes, listed in priority order.
  typedef enum logic [class_width_c-1:0] {
    cls_instr,
    cls_fp_instr,
    cls_flush,
    cls_icache_miss,
    cls_stall_depend,
    cls_stall_remote,
    cls_stall_barrier,
    cls_unknown
  } pc_class_e;

  typedef struct packed {
    logic [31:0] exe_pc;
    logic [31:0] fp_pc;             // pc of the op in the fp execute stage.
    logic        instr_valid;
    logic        fp_issue;
    logic        stall_all;
    logic        flush;
    logic        icache_miss;
    logic        stall_depend;
    logic        stall_remote;
    logic        stall_barrier;
    logic [1:0]  spare;             // tied to zero by the core.
  } core_status_s;

  typedef struct packed {
    logic                      valid;
    logic                      in_range;
    pc_class_e                 cls;
    logic [max_bin_bits_c-1:0] bin;
  } hist_event_s;

  typedef struct packed {
    logic        enable;
    logic [31:0] pc_base;
    logic [4:0]  bin_shift;
    logic        clear_req;         // single cycle pulse.
  } prof_cfg_s;

  // word address as seen by the register file.
  typedef struct packed {
    logic       region;
    logic [6:0] pad;
    logic [3:0] reg_idx;
  } pc_prof_csr_addr_s;

  // word address as seen by the counter array.
  typedef struct packed {
    logic                      region;
    logic [max_bin_bits_c-1:0] bin;
    pc_class_e                 cls;
  } pc_prof_cnt_addr_s;

  // region 0 is registers, region 1 is counters.
  typedef union packed {
    pc_prof_csr_addr_s csr;
    pc_prof_cnt_addr_s counter;
  } pc_prof_addr_u;

  localparam logic [3:0] reg_ctrl_c      = 4'd0;
  localparam logic [3:0] reg_status_c    = 4'd1;
  localparam logic [3:0] reg_pc_base_c   = 4'd2;
  localparam logic [3:0] reg_bin_shift_c = 4'd3;
  localparam logic [3:0] reg_oor_count_c = 4'd4;

endpackage

// ==== hdl/pc_profiler_top.sv ====
module pc_profiler_top #(
  parameter int num_bins_p      = 64,
  parameter int counter_width_p = 32
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  pc_prof_pkg::core_status_s core_status_i,
  input  logic [13:0]               awaddr_i,
  input  logic                      awvalid_i,
  output logic                      awready_o,
  input  logic [31:0]               wdata_i,
  input  logic                      wvalid_i,
  output logic                      wready_o,
  output logic                      bvalid_o,
  output logic [1:0]                bresp_o,
  input  logic                      bready_i,
  input  logic [13:0]               araddr_i,
  input  logic                      arvalid_i,
  output logic                      arready_o,
  output logic                      rvalid_o,
  output logic [31:0]               rdata_o,
  output logic [1:0]                rresp_o,
  input  logic                      rready_i
);

  pc_prof_pkg::hist_event_s   hist_event;
  pc_prof_pkg::prof_cfg_s     cfg;
  pc_prof_pkg::pc_prof_addr_u rd_addr;
  logic                       clear_busy;
  logic [31:0]                oor_count;
  logic                       rd_en;
  logic [31:0]                rd_data;

  pc_event_encoder #(
    .num_bins_p(num_bins_p)
  ) encoder (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .status_i   (core_status_i),
    .enable_i   (cfg.enable),
    .pc_base_i  (cfg.pc_base),
    .bin_shift_i(cfg.bin_shift),
    .event_o    (hist_event)
  );

  pc_hist_counters #(
    .num_bins_p     (num_bins_p),
    .counter_width_p(counter_width_p)
  ) counters (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .event_i     (hist_event),
    .clear_i     (cfg.clear_req),
    .clear_busy_o(clear_busy),
    .oor_count_o (oor_count),
    .rd_en_i     (rd_en),
    .rd_addr_i   (rd_addr),
    .rd_data_o   (rd_data)
  );

  pc_prof_csr csr (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .awaddr_i    (awaddr_i),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .wdata_i     (wdata_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .bvalid_o    (bvalid_o),
    .bresp_o     (bresp_o),
    .bready_i    (bready_i),
    .araddr_i    (araddr_i),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .rresp_o     (rresp_o),
    .rready_i    (rready_i),
    .cfg_o       (cfg),
    .clear_busy_i(clear_busy),
    .oor_count_i (oor_count),
    .rd_en_o     (rd_en),
    .rd_addr_o   (rd_addr),
    .rd_data_i   (rd_data)
  );

endmodule

// ==== tb/pc_profiler_tb.sv ====
module pc_profiler_tb;

  localparam int num_bins_lp = 16;
  localparam int counter_width_lp = 8;
  localparam int counter_max_lp = (1 << counter_width_lp) - 1;
  localparam int timeout_lp = 2 * (600 + 300 + 20 + 2 * 128 + 136 * 4 + 200);

  logic clk_i;
  logic reset_i;
  pc_prof_pkg::core_status_s core_status;
  logic [13:0] awaddr;
  logic awvalid;
  logic awready;
  logic [31:0] wdata;
  logic wvalid;
  logic wready;
  logic bvalid;
  logic [1:0] bresp;
  logic bready;
  logic [13:0] araddr;
  logic arvalid;
  logic arready;
  logic rvalid;
  logic [31:0] rdata;
  logic [1:0] rresp;
  logic rready;

  int unsigned model_cnt [num_bins_lp][8];
  int unsigned model_oor;
  logic model_en;
  logic [31:0] model_base;
  logic [4:0] model_shift;
  int checks;
  int errors;
  int cycle_count;

  pc_profiler_top #(
    .num_bins_p(num_bins_lp),
    .counter_width_p(counter_width_lp)
  ) dut (
    .clk_i(clk_i), .reset_i(reset_i), .core_status_i(core_status),
    .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
    .wdata_i(wdata), .wvalid_i(wvalid), .wready_o(wready),
    .bvalid_o(bvalid), .bresp_o(bresp), .bready_i(bready),
    .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
    .rvalid_o(rvalid), .rdata_o(rdata), .rresp_o(rresp), .rready_i(rready)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [13:0] reg_addr(logic [3:0] idx);
    return {8'b0, idx, 2'b00};
  endfunction

  function automatic logic [13:0] counter_addr(int bin, int cls);
    return 14'((1 << 13) | (bin << 5) | (cls << 2));
  endfunction

  function automatic void clear_model();
    foreach (model_cnt[b, c]) begin
      model_cnt[b][c] = 0;
    end
    model_oor = 0;
  endfunction

  // one status word as the profiler should count it.
  function automatic void record_event(pc_prof_pkg::core_status_s s);
    int cls;
    logic [31:0] pc;
    logic [31:0] shifted;
    pc = s.exe_pc;
    if (s.instr_valid && !s.stall_all) begin
      cls = 0;
    end else if (s.fp_issue && !s.stall_all) begin
      cls = 1;
      pc  = s.fp_pc;
    end else if (s.flush) begin
      cls = 2;
    end else if (s.icache_miss) begin
      cls = 3;
    end else if (s.stall_depend) begin
      cls = 4;
    end else if (s.stall_remote) begin
      cls = 5;
    end else if (s.stall_barrier) begin
      cls = 6;
    end else begin
      cls = 7;
    end
    shifted = (pc - model_base) >> model_shift;
    if (shifted < num_bins_lp) begin
      if (model_cnt[shifted][cls] < counter_max_lp) begin
        model_cnt[shifted][cls]++;
      end
    end else if (model_oor != 32'hffff_ffff) begin
      model_oor++;
    end
  endfunction

  function automatic void apply_write(logic [13:0] addr, logic [31:0] data);
    if (addr[13:6] == 8'd0) begin
      case (addr[5:2])
        pc_prof_pkg::reg_ctrl_c: begin
          model_en = data[0];
          if (data[1]) begin
            clear_model();
          end
        end
        pc_prof_pkg::reg_pc_base_c:   model_base = data;
        pc_prof_pkg::reg_bin_shift_c: model_shift = data[4:0];
        default: ;
      endcase
    end
  endfunction

  // flags are biased low so that the lower priority classes show up too.
  function automatic pc_prof_pkg::core_status_s random_status();
    pc_prof_pkg::core_status_s s;
    s = '0;
    s.exe_pc        = 32'h0000_0ff0 + ($urandom % 32'h60);
    s.fp_pc         = 32'h0000_0ff0 + ($urandom % 32'h60);
    s.instr_valid   = ($urandom % 4) == 0;
    s.fp_issue      = ($urandom % 4) == 0;
    s.stall_all     = ($urandom % 4) == 0;
    s.flush         = ($urandom % 5) == 0;
    s.icache_miss   = ($urandom % 5) == 0;
    s.stall_depend  = ($urandom % 4) == 0;
    s.stall_remote  = ($urandom % 3) == 0;
    s.stall_barrier = ($urandom % 2) == 0;
    return s;
  endfunction

  task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic write_word(input logic [13:0] addr, input logic [31:0] data);
    logic aw_done;
    logic w_done;
    int hold;
    aw_done = 1'b0;
    w_done  = 1'b0;
    hold    = $urandom % 6;
    @(posedge clk_i);
    #10;
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wvalid  = 1'b1;
    while (!(aw_done && w_done)) begin
      @(negedge clk_i);
      if (awvalid && awready) begin
        aw_done = 1'b1;
      end
      if (wvalid && wready) begin
        w_done = 1'b1;
      end
      @(posedge clk_i);
      #10;
      awvalid = awvalid && !aw_done;
      wvalid  = wvalid && !w_done;
    end
    @(posedge clk_i);
    #10;
    apply_write(addr, data);              // the register takes effect one edge after capture.
    @(negedge clk_i);
    while (!bvalid) begin
      @(negedge clk_i);
    end
    expect_equal(32'(bresp), 32'd0, "bresp");
    repeat (hold) begin
      @(negedge clk_i);
      checks++;
      assert (bvalid && bresp == 2'b00) else begin
        errors++;
        $display("[FAIL] %0t: write response dropped while bready was low", $time);
      end
    end
    @(posedge clk_i);
    #10;
    bready = 1'b1;
    @(posedge clk_i);
    #10;
    bready = 1'b0;
  endtask

  task automatic fetch_word(input logic [13:0] addr, output logic [31:0] data);
    int hold;
    hold = $urandom % 6;
    @(posedge clk_i);
    #10;
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk_i);
    while (!arready) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #10;
    arvalid = 1'b0;
    @(negedge clk_i);
    while (!rvalid) begin
      @(negedge clk_i);
    end
    data = rdata;
    expect_equal(32'(rresp), 32'd0, "rresp");
    repeat (hold) begin
      @(negedge clk_i);
      checks++;
      assert (rvalid && rdata === data) else begin
        errors++;
        $display("[FAIL] %0t: read data changed while rready was low", $time);
      end
    end
    @(posedge clk_i);
    #10;
    rready = 1'b1;
    @(posedge clk_i);
    #10;
    rready = 1'b0;
  endtask

  task automatic clear_counters();
    logic [31:0] status;
    int start_cycle;
    start_cycle = cycle_count;
    write_word(reg_addr(pc_prof_pkg::reg_ctrl_c), 32'd2);
    fetch_word(reg_addr(pc_prof_pkg::reg_status_c), status);
    expect_equal(status, 32'd1, "status during clear");
    while (status[0] && (cycle_count - start_cycle) < 2 * num_bins_lp * 8) begin
      fetch_word(reg_addr(pc_prof_pkg::reg_status_c), status);
    end
    expect_equal(status, 32'd0, "status after clear");
  endtask

  task automatic check_all_counters();
    logic [31:0] got;
    for (int b = 0; b < num_bins_lp; b++) begin
      for (int c = 0; c < 8; c++) begin
        fetch_word(counter_addr(b, c), got);
        expect_equal(got, model_cnt[b][c], $sformatf("counter bin %0d class %0d", b, c));
      end
    end
    fetch_word(reg_addr(pc_prof_pkg::reg_oor_count_c), got);
    expect_equal(got, model_oor, "oor count");
  endtask

  // the word on the bus at a falling edge is what the next rising edge samples.
  initial begin
    forever begin
      @(negedge clk_i);
      if (model_en) begin
        record_event(core_status);
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count <= timeout_lp) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", timeout_lp);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    logic [31:0] got;
    void'($urandom(23392));
    checks = 0;
    errors = 0;
    model_en = 1'b0;
    model_base = '0;
    model_shift = '0;
    clear_model();
    reset_i = 1'b1;
    core_status = '0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    repeat (2) @(posedge clk_i);
    #10;
    reset_i = 1'b0;

    fetch_word(reg_addr(pc_prof_pkg::reg_ctrl_c), got);
    expect_equal(got, 32'd0, "ctrl after reset");
    fetch_word(reg_addr(pc_prof_pkg::reg_pc_base_c), got);
    expect_equal(got, 32'd0, "pc_base after reset");
    fetch_word(reg_addr(pc_prof_pkg::reg_bin_shift_c), got);
    expect_equal(got, 32'd0, "bin_shift after reset");
    write_word(reg_addr(pc_prof_pkg::reg_pc_base_c), 32'h0000_1000);
    write_word(reg_addr(pc_prof_pkg::reg_bin_shift_c), 32'd2);
    fetch_word(reg_addr(pc_prof_pkg::reg_pc_base_c), got);
    expect_equal(got, 32'h0000_1000, "pc_base");
    fetch_word(reg_addr(pc_prof_pkg::reg_bin_shift_c), got);
    expect_equal(got, 32'd2, "bin_shift");
    clear_counters();
    check_all_counters();

    write_word(reg_addr(pc_prof_pkg::reg_ctrl_c), 32'd1);
    repeat (600) begin
      @(posedge clk_i);
      #10;
      core_status = random_status();
    end
    write_word(reg_addr(pc_prof_pkg::reg_ctrl_c), 32'd0);
    repeat (10) @(posedge clk_i);
    check_all_counters();

    clear_counters();
    core_status = '0;
    core_status.instr_valid = 1'b1;
    core_status.exe_pc = 32'h0000_1014;   // bin 5 of the window.
    write_word(reg_addr(pc_prof_pkg::reg_ctrl_c), 32'd1);
    repeat (300) @(posedge clk_i);
    #10;
    core_status.instr_valid = 1'b0;
    core_status.fp_issue = 1'b1;
    for (int i = 0; i < 20; i++) begin
      @(posedge clk_i);
      #10;
      core_status.fp_pc = (i % 2) ? 32'h0000_1020 : 32'h0000_101c;
    end
    write_word(reg_addr(pc_prof_pkg::reg_ctrl_c), 32'd0);
    repeat (10) @(posedge clk_i);
    fetch_word(counter_addr(5, 0), got);
    expect_equal(got, model_cnt[5][0], "saturated counter");
    fetch_word(counter_addr(7, 1), got);
    expect_equal(got, model_cnt[7][1], "fp counter bin 7");
    fetch_word(counter_addr(8, 1), got);
    expect_equal(got, model_cnt[8][1], "fp counter bin 8");
    fetch_word(reg_addr(pc_prof_pkg::reg_oor_count_c), got);
    expect_equal(got, model_oor, "oor count");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
